// ==== hdl/mmu_defs.svh ====
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// ==================================================
// Grid geometry
// ==================================================
`define MMU_N       4                   // Grid side, also lanes per operand vector
`define MMU_ROW_W   2                   // Row index into the result buffer

// ==================================================
// Data widths
// ==================================================
`define MMU_DATA_W  8                   // Signed operand
`define MMU_ACC_W   24                  // Accumulator, wraps modulo 2**24
`define MMU_KLEN_W  8                   // Job length, 1 to 255 steps

// Drain time after the last step, covers skew plus grid diagonal
`define MMU_FLUSH   (2 * `MMU_N)

`endif

// ==== hdl/mmu_pkg.sv ====
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

    // Scalar element types
    typedef logic signed [`MMU_DATA_W-1:0] operand_t;
    typedef logic signed [`MMU_ACC_W-1:0]  acc_t;

    // One operand step, lane 0 in the low byte
    // A lane i carries matrix row i, B lane j carries matrix column j
    typedef operand_t [`MMU_N-1:0] operand_vec_t;

    // One result row, element j is column j
    typedef acc_t [`MMU_N-1:0] acc_row_t;

    // Whole grid of sums, row i at index i
    typedef acc_row_t [`MMU_N-1:0] acc_grid_t;

endpackage

`default_nettype wire

// ==== hdl/pe_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module pe_cell (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                clear,
    input  wire                valid_in,
    input  wire mmu_pkg::operand_t a_in,
    input  wire mmu_pkg::operand_t b_in,
    output logic               valid_out,
    output mmu_pkg::operand_t  a_out,
    output mmu_pkg::operand_t  b_out,
    output mmu_pkg::acc_t      acc
);

    logic signed [2*`MMU_DATA_W-1:0] prod;    // Full signed product

    assign prod = a_in * b_in;

    // Operands hop one cell per cycle
    always_ff @(posedge clk) begin
        a_out <= a_in;                        // A moves right
        b_out <= b_in;                        // B moves down
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            acc       <= '0;
        end else begin
            valid_out <= valid_in;
            if (clear) begin
                acc <= '0;                    // New job
            end else if (valid_in) begin
                acc <= acc + mmu_pkg::acc_t'(prod);  // Wraps at 24 bits
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/systolic_grid.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module systolic_grid (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        clear,
    input  wire mmu_pkg::operand_vec_t a_edge,
    input  wire mmu_pkg::operand_vec_t b_edge,
    input  wire [`MMU_N-1:0]           a_valid_edge,
    output wire mmu_pkg::acc_grid_t    sums
);

    // ==================================================
    // Inter-cell wiring
    // ==================================================
    // Index 0 of each chain is the grid edge, index k+1 is the output of cell k
    mmu_pkg::operand_t       a_chain [`MMU_N][`MMU_N+1];  // [row][col]
    mmu_pkg::operand_t       b_chain [`MMU_N][`MMU_N+1];  // [col][row]
    logic [`MMU_N-1:0][`MMU_N:0] v_chain;                 // Valid rides with A

    // ==================================================
    // Cell array
    // ==================================================
    for (genvar i = 0; i < `MMU_N; i++) begin : g_row
        // Left edge of row i, top edge of column i
        assign a_chain[i][0] = a_edge[i];
        assign b_chain[i][0] = b_edge[i];
        assign v_chain[i][0] = a_valid_edge[i];

        for (genvar j = 0; j < `MMU_N; j++) begin : g_col
            pe_cell pe_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .clear     (clear),
                .valid_in  (v_chain[i][j]),
                .a_in      (a_chain[i][j]),
                .b_in      (b_chain[j][i]),
                .valid_out (v_chain[i][j+1]),
                .a_out     (a_chain[i][j+1]),
                .b_out     (b_chain[j][i+1]),
                .acc       (sums[i][j])
            );
        end
    end

    // Unknown valid anywhere in the array would corrupt sums silently
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(v_chain)
    ) else $error("systolic_grid: unknown valid flag in array");

endmodule

`default_nettype wire

// ==== hdl/operand_skew.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module operand_skew (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        step_valid,
    input  wire mmu_pkg::operand_vec_t a_vec,
    input  wire mmu_pkg::operand_vec_t b_vec,
    output wire mmu_pkg::operand_vec_t a_edge,
    output wire mmu_pkg::operand_vec_t b_edge,
    output wire [`MMU_N-1:0]           a_valid_edge
);

    // Lane 0 enters the grid in the same cycle
    assign a_edge[0]       = a_vec[0];
    assign b_edge[0]       = b_vec[0];
    assign a_valid_edge[0] = step_valid;

    // ==================================================
    // Lane i delayed by i stages
    // ==================================================
    for (genvar i = 1; i < `MMU_N; i++) begin : g_lane
        mmu_pkg::operand_t a_sr [i];
        mmu_pkg::operand_t b_sr [i];
        logic [i-1:0]      v_sr;

        // Operand payload, no reset needed
        always_ff @(posedge clk) begin
            a_sr[0] <= a_vec[i];
            b_sr[0] <= b_vec[i];
            for (int k = 1; k < i; k++) begin
                a_sr[k] <= a_sr[k-1];
                b_sr[k] <= b_sr[k-1];
            end
        end

        // Valid flag follows the A lane
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                v_sr <= '0;
            end else begin
                v_sr[0] <= step_valid;
                for (int k = 1; k < i; k++) begin
                    v_sr[k] <= v_sr[k-1];
                end
            end
        end

        assign a_edge[i]       = a_sr[i-1];
        assign b_edge[i]       = b_sr[i-1];
        assign a_valid_edge[i] = v_sr[i-1];   // Last stage
    end

endmodule

`default_nettype wire

// ==== hdl/mmu_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_sequencer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire [`MMU_KLEN_W-1:0] k_len,
    input  wire                   in_valid,
    output logic                  step_valid,
    output logic                  clear,
    output logic                  save,
    output logic                  busy,
    output logic                  done
);

    localparam int FLUSH_W = $clog2(`MMU_FLUSH);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_FEED,
        ST_FLUSH,
        ST_SAVE,
        ST_DONE
    } state_t;

    state_t                 state;
    logic [`MMU_KLEN_W-1:0] k_len_q;      // Latched job length
    logic [`MMU_KLEN_W-1:0] step_cnt;     // Steps accepted so far
    logic [FLUSH_W-1:0]     flush_cnt;

    // ==================================================
    // Decoded outputs
    // ==================================================
    assign step_valid = in_valid && (state == ST_FEED);   // Strobes elsewhere dropped
    assign clear      = (state == ST_CLEAR);
    assign save       = (state == ST_SAVE);
    assign done       = (state == ST_DONE);
    assign busy       = (state != ST_IDLE);

    // ==================================================
    // Job FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            k_len_q   <= '0;
            step_cnt  <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_CLEAR;
                        k_len_q  <= k_len;
                        step_cnt <= '0;
                    end
                end

                ST_CLEAR: state <= ST_FEED;   // Accumulators zeroed this cycle

                ST_FEED: begin
                    if (step_valid) begin
                        step_cnt <= step_cnt + 1'b1;
                        if (step_cnt == k_len_q - 1'b1) begin
                            state     <= ST_FLUSH;
                            flush_cnt <= '0;
                        end
                    end
                end

                // Let the last step drain through skew and grid
                ST_FLUSH: begin
                    if (flush_cnt == FLUSH_W'(`MMU_FLUSH - 1)) begin
                        state <= ST_SAVE;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end

                ST_SAVE: state <= ST_DONE;
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Zero length would wrap the step compare and run 256 steps
    k_len_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && !busy) |-> (k_len != '0)
    ) else $error("mmu_sequencer: job started with k_len of zero");

endmodule

`default_nettype wire

// ==== hdl/result_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module result_buffer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     save,
    input  wire mmu_pkg::acc_grid_t sums,
    input  wire                     rd_en,
    input  wire [`MMU_ROW_W-1:0]    rd_row,
    output logic                    rd_valid,
    output mmu_pkg::acc_row_t       rd_data
);

    mmu_pkg::acc_grid_t grid_q;    // Last finished result

    // Snapshot of the whole grid, zero until the first job ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grid_q <= '0;
        end else if (save) begin
            grid_q <= sums;
        end
    end

    // ==================================================
    // Row read port, one cycle latency
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= grid_q[rd_row];   // Old result while a job runs
        end
    end

    // A second save would capture a grid that is already being cleared
    save_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        save |=> !save
    ) else $error("result_buffer: save in adjacent cycles");

endmodule

`default_nettype wire

// ==== hdl/mmu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start,
    input  wire [`MMU_KLEN_W-1:0]      k_len,
    input  wire                        in_valid,
    input  wire mmu_pkg::operand_vec_t a_vec,
    input  wire mmu_pkg::operand_vec_t b_vec,
    input  wire                        rd_en,
    input  wire [`MMU_ROW_W-1:0]       rd_row,
    output wire                        busy,
    output wire                        done,
    output wire                        rd_valid,
    output wire mmu_pkg::acc_row_t     rd_data
);

    wire                        step_valid;
    wire                        clear;
    wire                        save;
    wire mmu_pkg::operand_vec_t a_edge;
    wire mmu_pkg::operand_vec_t b_edge;
    wire [`MMU_N-1:0]           a_valid_edge;
    wire mmu_pkg::acc_grid_t    sums;

    // ==================================================
    // Control
    // ==================================================
    mmu_sequencer seq_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .k_len      (k_len),
        .in_valid   (in_valid),
        .step_valid (step_valid),
        .clear      (clear),
        .save       (save),
        .busy       (busy),
        .done       (done)
    );

    // ==================================================
    // Datapath
    // ==================================================
    operand_skew skew_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .step_valid   (step_valid),
        .a_vec        (a_vec),
        .b_vec        (b_vec),
        .a_edge       (a_edge),
        .b_edge       (b_edge),
        .a_valid_edge (a_valid_edge)
    );

    systolic_grid grid_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .a_edge       (a_edge),
        .b_edge       (b_edge),
        .a_valid_edge (a_valid_edge),
        .sums         (sums)
    );

    result_buffer rbuf_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .save     (save),
        .sums     (sums),
        .rd_en    (rd_en),
        .rd_row   (rd_row),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// ==== sim/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module tb_checker (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start,
    input  wire [`MMU_KLEN_W-1:0]      k_len,
    input  wire                        in_valid,
    input  wire mmu_pkg::operand_vec_t a_vec,
    input  wire mmu_pkg::operand_vec_t b_vec,
    input  wire                        rd_en,
    input  wire [`MMU_ROW_W-1:0]       rd_row,
    input  wire                        busy,
    input  wire                        done,
    input  wire                        rd_valid,
    input  wire mmu_pkg::acc_row_t     rd_data,
    output int                         errors,
    output int                         checks
);

    localparam int DONE_DELAY = `MMU_FLUSH + 2;   // Flush, save, then done

    typedef enum logic [1:0] {
        M_IDLE,
        M_CLEAR,
        M_FEED,
        M_DRAIN
    } phase_t;

    phase_t                 phase;
    logic [`MMU_KLEN_W-1:0] klen_q;
    int                     step_cnt;
    int                     drain_cnt;
    mmu_pkg::acc_grid_t     model;       // Running sums of the job in flight
    mmu_pkg::acc_grid_t     expected;    // Result of the last finished job
    logic                   rd_en_q;
    logic [`MMU_ROW_W-1:0]  rd_row_q;

    // ==================================================
    // Reference model
    // ==================================================
    task automatic add_outer_product(input mmu_pkg::operand_vec_t a,
                                     input mmu_pkg::operand_vec_t b);
        int p;
        for (int i = 0; i < `MMU_N; i++) begin
            for (int j = 0; j < `MMU_N; j++) begin
                p = int'(a[i]) * int'(b[j]);                       // Signed 8 x 8
                model[i][j] = model[i][j] + mmu_pkg::acc_t'(p);    // Wraps at 24 bits
            end
        end
    endtask

    task automatic compare_row(input logic [`MMU_ROW_W-1:0] row,
                               input mmu_pkg::acc_row_t actual);
        for (int j = 0; j < `MMU_N; j++) begin
            checks++;
            if (actual[j] !== expected[row][j]) begin
                $display("Error: rd_data row %0d col %0d expected %h actual %h",
                         row, j, expected[row][j], actual[j]);
                errors++;
            end
        end
    endtask

    // ==================================================
    // Port monitor
    // ==================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     = M_IDLE;
            klen_q    = '0;
            step_cnt  = 0;
            drain_cnt = 0;
            model     = '0;
            expected  = '0;                // Buffer holds zeros after reset
            rd_en_q   = 1'b0;
            rd_row_q  = '0;
            errors    = 0;
            checks    = 0;
        end else begin
            // Read port, data due one cycle after the request
            if (rd_valid) begin
                if (!rd_en_q) begin
                    $display("Read data appeared without a read request");
                    errors++;
                end else begin
                    compare_row(rd_row_q, rd_data);
                end
            end else if (rd_en_q) begin
                $display("A read request got no data back");
                errors++;
            end
            rd_en_q  = rd_en;
            rd_row_q = rd_row;

            if (done && phase != M_DRAIN) begin
                $display("Done pulsed while no job was draining");
                errors++;
            end

            // Busy from the clear cycle through the done cycle
            checks++;
            if (busy !== (phase != M_IDLE)) begin
                $display("Error: busy expected %h actual %h", phase != M_IDLE, busy);
                errors++;
            end

            case (phase)
                M_IDLE: begin
                    if (start) begin
                        klen_q   = k_len;
                        step_cnt = 0;
                        model    = '0;
                        phase    = M_CLEAR;
                    end
                end
                M_CLEAR: phase = M_FEED;   // Strobes in this cycle are dropped
                M_FEED: begin
                    if (in_valid) begin
                        add_outer_product(a_vec, b_vec);
                        step_cnt++;
                        if (step_cnt == int'(klen_q)) begin
                            phase     = M_DRAIN;
                            drain_cnt = 0;
                        end
                    end
                end
                M_DRAIN: begin
                    drain_cnt++;
                    if (done) begin
                        if (drain_cnt != DONE_DELAY) begin
                            $display("Done arrived %0d cycles after the last step, not %0d",
                                     drain_cnt, DONE_DELAY);
                            errors++;
                        end
                        expected = model;  // Buffer updated one edge earlier
                        phase    = M_IDLE;
                    end else if (drain_cnt >= DONE_DELAY) begin
                        $display("Done never arrived after the last step of a job");
                        errors++;
                        phase = M_IDLE;
                    end
                end
                default: phase = M_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defs.svh"

module tb_top;

    localparam logic [31:0] SEED = 32'hf14b;
    localparam int MAX_GAP = 3;
    // Five jobs of at most 255 steps with gaps up to MAX_GAP, plus reads, stay far below this
    localparam int TIMEOUT_CYCLES = 20000;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic [`MMU_KLEN_W-1:0] k_len;
    logic                   in_valid;
    mmu_pkg::operand_vec_t  a_vec;
    mmu_pkg::operand_vec_t  b_vec;
    logic                   rd_en;
    logic [`MMU_ROW_W-1:0]  rd_row;
    wire                    busy;
    wire                    done;
    wire                    rd_valid;
    wire mmu_pkg::acc_row_t rd_data;
    int                     errors;
    int                     checks;

    logic [31:0] data_rng;     // Operand stream
    logic [31:0] gap_rng;      // Strobe gap stream
    logic [31:0] data_mark;
    logic [7:0]  len2;
    int          passed;
    int          failed;
    int          err_mark;
    int          cycle_cnt;

    mmu_top dut_i (
        .clk(clk), .rst_n(rst_n), .start(start), .k_len(k_len),
        .in_valid(in_valid), .a_vec(a_vec), .b_vec(b_vec),
        .rd_en(rd_en), .rd_row(rd_row), .busy(busy), .done(done),
        .rd_valid(rd_valid), .rd_data(rd_data)
    );

    tb_checker tb_checker_i (
        .clk(clk), .rst_n(rst_n), .start(start), .k_len(k_len),
        .in_valid(in_valid), .a_vec(a_vec), .b_vec(b_vec),
        .rd_en(rd_en), .rd_row(rd_row), .busy(busy), .done(done),
        .rd_valid(rd_valid), .rd_data(rd_data), .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic start_job(input logic [7:0] len);
        @(negedge clk);
        start = 1'b1;
        k_len = len;
        @(negedge clk);
        start = 1'b0;                   // Sequencer now in its clear cycle
    endtask

    task automatic drive_steps(input int len, input int max_gap, input bit all_min);
        int gap;
        for (int s = 0; s < len; s++) begin
            gap = 0;
            if (max_gap > 0) begin
                gap_rng = xorshift32(gap_rng);
                gap     = int'(gap_rng % (max_gap + 1));
            end
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            if (all_min) begin
                a_vec = {`MMU_N{8'h80}};        // Every lane -128
                b_vec = {`MMU_N{8'h80}};
            end else begin
                data_rng = xorshift32(data_rng);
                a_vec    = data_rng;
                data_rng = xorshift32(data_rng);
                b_vec    = data_rng;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic stray_strobe();
        @(negedge clk);
        in_valid = 1'b1;
        a_vec    = 32'h7f7f7f7f;
        b_vec    = 32'h7f7f7f7f;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) @(negedge clk);
    endtask

    task automatic read_rows();
        for (int r = 0; r < `MMU_N; r++) begin
            @(negedge clk);
            rd_en  = 1'b1;
            rd_row = r[`MMU_ROW_W-1:0];
        end
        @(negedge clk);
        rd_en = 1'b0;
        @(negedge clk);                 // Last row compared by now
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == err_mark) begin
            passed++;
            $display("Test %0d %s: pass", num, name);
        end else begin
            failed++;
            $display("Test %0d %s: fail with %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        k_len    = '0;
        in_valid = 1'b0;
        a_vec    = '0;
        b_vec    = '0;
        rd_en    = 1'b0;
        rd_row   = '0;
        data_rng = SEED;
        gap_rng  = xorshift32(~SEED);
        passed   = 0;
        failed   = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        err_mark = errors;

        start_job(8'd1);
        drive_steps(1, 0, 1'b0);
        wait_done();
        read_rows();
        report_test(1, "single step outer product");

        data_rng  = xorshift32(data_rng);
        len2      = 8'd2 + 8'(data_rng % 39);
        data_mark = data_rng;
        start_job(len2);
        drive_steps(len2, 0, 1'b0);
        wait_done();
        read_rows();
        report_test(2, "back to back steps");

        stray_strobe();                 // Idle, must not touch any sum
        data_rng = data_mark;
        start_job(len2);
        drive_steps(len2, MAX_GAP, 1'b0);
        stray_strobe();                 // Lands in the flush, before the save
        wait_done();
        read_rows();
        report_test(3, "steps with gaps");

        start_job(8'd255);
        drive_steps(255, 0, 1'b1);
        wait_done();
        read_rows();
        report_test(4, "full length at -128");

        start_job(8'd30);
        fork
            drive_steps(30, 0, 1'b0);
            begin
                repeat (3) @(negedge clk);
                start = 1'b1;           // Busy, so ignored
                k_len = 8'd3;
                @(negedge clk);
                start = 1'b0;
                read_rows();            // Still the previous result
            end
        join
        wait_done();
        read_rows();
        report_test(5, "start while busy and reads during a job");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 passed + failed, passed, failed, checks, errors);
        if (failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/mmu_pkg.sv
hdl/pe_cell.sv
hdl/systolic_grid.sv
hdl/operand_skew.sv
hdl/mmu_sequencer.sv
hdl/result_buffer.sv
hdl/mmu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the matrix-multiply testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_top \
    --Mdir obj_dir \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
